// File: common/bpu_cfg_pkg.sv
package bpu_cfg_pkg;

  // fetch address out of reset
  localparam logic [31:0] RESET_PC = 32'h1c00_0000;

  // default table sizes that the top level may override
  localparam int BTB_ADDR_W_DFLT = 6;
  localparam int BHT_ADDR_W_DFLT = 6;
  localparam int RAS_DEPTH_DFLT  = 8;

  localparam int BTB_TAG_W = 10;

  // local history length per BHT entry
  localparam int BHT_DATA_W = 4;

  // pc[11:10] joined with the local history
  localparam int LPHT_ADDR_W = 2 + BHT_DATA_W;

  // target kinds stored in the BTB
  localparam logic [1:0] TGT_NPC    = 2'd0;
  localparam logic [1:0] TGT_CALL   = 2'd1;
  localparam logic [1:0] TGT_RETURN = 2'd2;
  localparam logic [1:0] TGT_IMM    = 2'd3;

endpackage

// File: common/bpu_types_pkg.sv
package bpu_types_pkg;

  typedef struct packed {
    logic                              valid;
    // branch sits in the second slot
    logic                              fsc;
    logic [bpu_cfg_pkg::BTB_TAG_W-1:0] tag;
    // word address
    logic [29:0]                       target_pc;
    // direction comes from the local predictor
    logic                              cond;
    logic [1:0]                        kind;
  } btb_entry_t;

  typedef struct packed {
    logic        hit;
    logic        cond;
    logic [1:0]  kind;
    logic        fsc;
    logic [31:0] target;
  } btb_hit_t;

  typedef struct packed {
    logic                               taken;
    logic [1:0]                         lphr;
    logic [bpu_cfg_pkg::BHT_DATA_W-1:0] history;
  } dir_pred_t;

  // one-cycle record from execute with miss as the strobe
  typedef struct packed {
    logic                                             miss;
    logic [31:0]                                      pc;
    logic [31:0]                                      true_target;
    logic [1:0]                                       true_kind;
    logic                                             true_cond;
    logic                                             true_taken;
    logic [bpu_cfg_pkg::BHT_DATA_W-1:0]               history;
    logic [1:0]                                       lphr;
    logic [$clog2(bpu_cfg_pkg::RAS_DEPTH_DFLT)-1:0]   ras_ptr;
  } bpu_correct_t;

  // travels with the fetch block and comes back in a correction
  typedef struct packed {
    logic                                             taken;
    logic [1:0]                                       kind;
    logic [1:0]                                       lphr;
    logic [bpu_cfg_pkg::BHT_DATA_W-1:0]               history;
    logic [$clog2(bpu_cfg_pkg::RAS_DEPTH_DFLT)-1:0]   ras_ptr;
  } bpu_predict_t;

  typedef struct packed {
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic [1:0]  valid;
  } fetch_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

endpackage

// File: hdl/dp_table.sv
`timescale 1ns/100ps

module dp_table #(
  parameter int DATA_W   = 8,
  parameter int ADDR_W   = 4,
  parameter int READ_LAT = 1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] waddr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic              re_i,
  input  logic [ADDR_W-1:0] raddr_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // whole array clears in one reset cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  generate
    if (READ_LAT == 0) begin : g_comb_rd
      assign rdata_o = mem[raddr_i];
    end else begin : g_reg_rd
      logic [DATA_W-1:0] rdata_q;

      // holds the last read while re_i is low
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          rdata_q <= '0;
        end else if (re_i) begin
          rdata_q <= mem[raddr_i];
        end
      end

      assign rdata_o = rdata_q;
    end
  endgenerate

  a_read_lat : assert property (@(posedge clk) READ_LAT inside {0, 1});

endmodule

// File: btb/btb_lookup.sv
`timescale 1ns/100ps

module btb_lookup #(
  parameter int BTB_ADDR_W = bpu_cfg_pkg::BTB_ADDR_W_DFLT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        adv_i,
  input  logic [31:0]                 ppc_i,
  input  logic [31:0]                 pc_i,
  input  bpu_types_pkg::bpu_correct_t correct_i,
  output bpu_types_pkg::btb_hit_t     hit_o
);

  localparam int TAG_W  = bpu_cfg_pkg::BTB_TAG_W;
  localparam int TAG_LO = BTB_ADDR_W + 3;

  // one entry per 8-byte block
  function automatic logic [BTB_ADDR_W-1:0] btb_index(input logic [31:0] pc);
    return pc[BTB_ADDR_W+2:3];
  endfunction

  function automatic logic [TAG_W-1:0] btb_tag(input logic [31:0] pc);
    return pc[TAG_LO +: TAG_W];
  endfunction

  bpu_types_pkg::btb_entry_t wr_entry;
  bpu_types_pkg::btb_entry_t rd_entry;
  logic [BTB_ADDR_W-1:0]     wr_idx;
  logic [BTB_ADDR_W-1:0]     rd_idx;
  logic                      tag_match;

  assign wr_idx = btb_index(correct_i.pc);
  assign rd_idx = btb_index(ppc_i);

  // fresh entry from the correction record
  always_comb begin
    wr_entry.valid     = 1'b1;
    wr_entry.fsc       = correct_i.pc[2];
    wr_entry.tag       = btb_tag(correct_i.pc);
    wr_entry.target_pc = correct_i.true_target[31:2];
    wr_entry.cond      = correct_i.true_cond;
    wr_entry.kind      = correct_i.true_kind;
  end

  // read at ppc, so the data lines up with pc on the next cycle
  dp_table #(
    .DATA_W  ($bits(bpu_types_pkg::btb_entry_t)),
    .ADDR_W  (BTB_ADDR_W),
    .READ_LAT(1)
  ) u_btb_table (
    .clk    (clk),
    .rst_n  (rst_n),
    .we_i   (correct_i.miss),
    .waddr_i(wr_idx),
    .wdata_i(wr_entry),
    .re_i   (adv_i),
    .raddr_i(rd_idx),
    .rdata_o(rd_entry)
  );

  assign tag_match = rd_entry.valid && (rd_entry.tag == btb_tag(pc_i));

  always_comb begin
    // slot 1 only fetch needs a slot 1 branch
    hit_o.hit    = tag_match && (!pc_i[2] || rd_entry.fsc);
    hit_o.cond   = rd_entry.cond;
    hit_o.kind   = rd_entry.kind;
    hit_o.fsc    = rd_entry.fsc;
    hit_o.target = {rd_entry.target_pc, 2'b00};
  end

  // a stalled block keeps its BTB result even across a correction
  a_stall_hit : assert property (
    @(posedge clk) disable iff (!rst_n) !adv_i |=> $stable(hit_o)
  );

endmodule

// File: dir/local_dir_pred.sv
`timescale 1ns/100ps

module local_dir_pred #(
  parameter int BHT_ADDR_W = bpu_cfg_pkg::BHT_ADDR_W_DFLT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        adv_i,
  input  logic [31:0]                 ppc_i,
  input  logic [31:0]                 pc_i,
  input  bpu_types_pkg::bpu_correct_t correct_i,
  output bpu_types_pkg::dir_pred_t    dir_o
);

  localparam int HIST_W = bpu_cfg_pkg::BHT_DATA_W;
  localparam int LPHT_W = bpu_cfg_pkg::LPHT_ADDR_W;

  // fold two block-address fields together
  function automatic logic [BHT_ADDR_W-1:0] bht_index(input logic [31:0] pc);
    return pc[BHT_ADDR_W+2:3] ^ pc[2*BHT_ADDR_W+2:BHT_ADDR_W+3];
  endfunction

  function automatic logic [1:0] next_lphr(input logic [1:0] old, input logic taken);
    case (old)
      2'b00:   return {1'b0, taken};
      2'b01:   return {taken, 1'b0};
      2'b10:   return {taken, 1'b1};
      default: return {1'b1, taken};
    endcase
  endfunction

  logic [BHT_ADDR_W-1:0] bht_idx_q;
  logic [HIST_W-1:0]     bht_rdata;
  logic [LPHT_W-1:0]     lpht_ridx;
  logic [1:0]            lphr_rdata;
  logic                  upd;
  logic [BHT_ADDR_W-1:0] bht_widx;
  logic [HIST_W-1:0]     bht_wdata;
  logic [LPHT_W-1:0]     lpht_widx;
  logic [1:0]            lpht_wdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bht_idx_q <= bht_index(bpu_cfg_pkg::RESET_PC);
    end else if (adv_i) begin
      bht_idx_q <= bht_index(ppc_i);
    end
  end

  // only conditional branches train history
  assign upd        = correct_i.miss && correct_i.true_cond;
  assign bht_widx   = bht_index(correct_i.pc);
  assign bht_wdata  = {correct_i.history[HIST_W-2:0], correct_i.true_taken};
  // the pattern entry that produced this prediction
  assign lpht_widx  = {correct_i.pc[11:10], correct_i.history};
  assign lpht_wdata = next_lphr(correct_i.lphr, correct_i.true_taken);

  dp_table #(
    .DATA_W  (HIST_W),
    .ADDR_W  (BHT_ADDR_W),
    .READ_LAT(0)
  ) u_bht (
    .clk    (clk),
    .rst_n  (rst_n),
    .we_i   (upd),
    .waddr_i(bht_widx),
    .wdata_i(bht_wdata),
    .re_i   (1'b1),
    .raddr_i(bht_idx_q),
    .rdata_o(bht_rdata)
  );

  assign lpht_ridx = {pc_i[11:10], bht_rdata};

  dp_table #(
    .DATA_W  (2),
    .ADDR_W  (LPHT_W),
    .READ_LAT(0)
  ) u_lpht (
    .clk    (clk),
    .rst_n  (rst_n),
    .we_i   (upd),
    .waddr_i(lpht_widx),
    .wdata_i(lpht_wdata),
    .re_i   (1'b1),
    .raddr_i(lpht_ridx),
    .rdata_o(lphr_rdata)
  );

  always_comb begin
    dir_o.taken   = lphr_rdata[1];
    dir_o.lphr    = lphr_rdata;
    dir_o.history = bht_rdata;
  end

endmodule

// File: hdl/npc_select.sv
`timescale 1ns/100ps

module npc_select #(
  parameter int RAS_DEPTH = bpu_cfg_pkg::RAS_DEPTH_DFLT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stall_i,
  input  bpu_types_pkg::redirect_t    redirect_i,
  input  bpu_types_pkg::bpu_correct_t correct_i,
  input  bpu_types_pkg::btb_hit_t     btb_i,
  input  bpu_types_pkg::dir_pred_t    dir_i,
  output logic [31:0]                 ppc_o,
  output logic [31:0]                 pc_o,
  output logic                        adv_o,
  output bpu_types_pkg::fetch_t       fetch_o,
  output bpu_types_pkg::bpu_predict_t predict_o
);

  localparam int PTR_W      = $clog2(RAS_DEPTH);
  localparam int META_PTR_W = $bits(correct_i.ras_ptr);

  logic [31:0]      pc_q;
  logic [31:0]      blk_pc;
  logic [31:0]      seq_pc;
  logic [31:0]      ppc;
  logic [31:0]      ret_addr;
  logic [31:0]      ras_top;
  logic [31:0]      ras_q [RAS_DEPTH];
  logic [PTR_W-1:0] ras_ptr_q;
  logic [PTR_W-1:0] crr_ptr;
  logic             cond_taken;
  logic             is_ret;
  logic             is_jump;
  logic             pred_taken;
  logic             push;
  logic             pop;
  logic [1:0]       mask;

  assign adv_o  = !stall_i;
  assign blk_pc = {pc_q[31:3], 3'b000};
  assign seq_pc = blk_pc + 32'd8;

  // return lands on the slot after the call
  assign ret_addr = btb_i.fsc ? seq_pc : blk_pc + 32'd4;
  assign ras_top  = ras_q[ras_ptr_q - PTR_W'(1)];
  assign crr_ptr  = PTR_W'(correct_i.ras_ptr);

  always_comb begin
    cond_taken = btb_i.hit && btb_i.cond && dir_i.taken;
    is_ret     = btb_i.hit && !btb_i.cond && (btb_i.kind == bpu_cfg_pkg::TGT_RETURN);
    is_jump    = btb_i.hit && !btb_i.cond &&
                 (btb_i.kind == bpu_cfg_pkg::TGT_CALL || btb_i.kind == bpu_cfg_pkg::TGT_IMM);
    pred_taken = cond_taken || is_ret || is_jump;

    ppc = seq_pc;
    if (redirect_i.valid) begin
      ppc = redirect_i.target;
    end else if (cond_taken) begin
      ppc = btb_i.target;
    end else if (is_ret) begin
      ppc = ras_top;
    end else if (is_jump) begin
      ppc = btb_i.target;
    end
  end

  always_comb begin
    mask = pc_q[2] ? 2'b10 : 2'b11;
    // slot 1 is dead behind a taken slot 0 branch
    if (pred_taken && !btb_i.fsc) begin
      mask = 2'b01;
    end
    if (stall_i) begin
      mask = 2'b00;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= bpu_cfg_pkg::RESET_PC;
    end else if (adv_o) begin
      pc_q <= ppc;
    end
  end

  assign push = adv_o && is_jump && (btb_i.kind == bpu_cfg_pkg::TGT_CALL);
  assign pop  = adv_o && is_ret;

  // corrections win over this cycle's push or pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ras_ptr_q <= '0;
      for (int i = 0; i < RAS_DEPTH; i++) begin
        ras_q[i] <= '0;
      end
    end else if (correct_i.miss) begin
      if (correct_i.true_kind == bpu_cfg_pkg::TGT_CALL) begin
        ras_q[crr_ptr] <= correct_i.pc + 32'd4;
        ras_ptr_q      <= crr_ptr + PTR_W'(1);
      end else begin
        ras_ptr_q <= crr_ptr;
      end
    end else if (push) begin
      ras_q[ras_ptr_q] <= ret_addr;
      ras_ptr_q        <= ras_ptr_q + PTR_W'(1);
    end else if (pop) begin
      ras_ptr_q <= ras_ptr_q - PTR_W'(1);
    end
  end

  assign ppc_o = ppc;
  assign pc_o  = pc_q;

  always_comb begin
    fetch_o.pc0   = blk_pc;
    fetch_o.pc1   = {pc_q[31:3], 3'b100};
    fetch_o.valid = mask;
  end

  always_comb begin
    predict_o.taken   = pred_taken;
    predict_o.kind    = btb_i.hit ? btb_i.kind : bpu_cfg_pkg::TGT_NPC;
    predict_o.lphr    = dir_i.lphr;
    predict_o.history = dir_i.history;
    // pointer before this block's push or pop
    predict_o.ras_ptr = META_PTR_W'(ras_ptr_q);
  end

  // a stall without a correction holds both the pc and the ras pointer
  a_stall_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    stall_i && !correct_i.miss |=> $stable(pc_q) && $stable(ras_ptr_q)
  );

endmodule

// File: hdl/bpu_top.sv
`timescale 1ns/100ps

module bpu_top #(
  parameter int BTB_ADDR_W = bpu_cfg_pkg::BTB_ADDR_W_DFLT,
  parameter int BHT_ADDR_W = bpu_cfg_pkg::BHT_ADDR_W_DFLT,
  parameter int RAS_DEPTH  = bpu_cfg_pkg::RAS_DEPTH_DFLT
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stall_i,
  input  bpu_types_pkg::redirect_t    redirect_i,
  input  bpu_types_pkg::bpu_correct_t correct_i,
  output bpu_types_pkg::fetch_t       fetch_o,
  output bpu_types_pkg::bpu_predict_t predict_o
);

  logic [31:0]              ppc;
  logic [31:0]              pc;
  logic                     adv;
  bpu_types_pkg::btb_hit_t  btb_hit;
  bpu_types_pkg::dir_pred_t dir_pred;

  btb_lookup #(
    .BTB_ADDR_W(BTB_ADDR_W)
  ) u_btb (
    .clk      (clk),
    .rst_n    (rst_n),
    .adv_i    (adv),
    .ppc_i    (ppc),
    .pc_i     (pc),
    .correct_i(correct_i),
    .hit_o    (btb_hit)
  );

  local_dir_pred #(
    .BHT_ADDR_W(BHT_ADDR_W)
  ) u_dir (
    .clk      (clk),
    .rst_n    (rst_n),
    .adv_i    (adv),
    .ppc_i    (ppc),
    .pc_i     (pc),
    .correct_i(correct_i),
    .dir_o    (dir_pred)
  );

  npc_select #(
    .RAS_DEPTH(RAS_DEPTH)
  ) u_npc (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall_i   (stall_i),
    .redirect_i(redirect_i),
    .correct_i (correct_i),
    .btb_i     (btb_hit),
    .dir_i     (dir_pred),
    .ppc_o     (ppc),
    .pc_o      (pc),
    .adv_o     (adv),
    .fetch_o   (fetch_o),
    .predict_o (predict_o)
  );

endmodule

// File: dv/bpu_checker.sv
`timescale 1ns/100ps

module bpu_checker (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stall_i,
  input  bpu_types_pkg::redirect_t    redirect_i,
  input  bpu_types_pkg::bpu_correct_t correct_i,
  input  bpu_types_pkg::fetch_t       fetch_i,
  input  bpu_types_pkg::bpu_predict_t predict_i,
  output bpu_types_pkg::bpu_predict_t exp_pred_o,
  output int                          err_cnt_o,
  output int                          chk_cnt_o
);

  typedef struct packed {
    bpu_types_pkg::fetch_t       fetch;
    bpu_types_pkg::bpu_predict_t pred;
    logic [31:0]                 npc;
    logic                        push;
    logic                        pop;
    logic [31:0]                 push_addr;
  } ref_out_t;

  // model state sized for the default top-level parameters
  logic [31:0]                 m_pc;
  bpu_types_pkg::btb_entry_t   m_btb [64];
  bpu_types_pkg::btb_entry_t   m_btb_rd;
  logic [3:0]                  m_bht [64];
  logic [1:0]                  m_lpht [64];
  logic [31:0]                 m_ras [8];
  logic [2:0]                  m_ptr;
  bpu_types_pkg::bpu_predict_t exp_pred;
  int                          errs = 0;
  int                          checks = 0;

  assign exp_pred_o = exp_pred;
  assign err_cnt_o  = errs;
  assign chk_cnt_o  = checks;

  function automatic logic [5:0] bht_slot(input logic [31:0] pc);
    return pc[8:3] ^ pc[14:9];
  endfunction

  function automatic logic [1:0] lphr_after(input logic [1:0] old, input logic taken);
    case (old)
      2'b00:   return {1'b0, taken};
      2'b01:   return {taken, 1'b0};
      2'b10:   return {taken, 1'b1};
      default: return {1'b1, taken};
    endcase
  endfunction

  // expected outputs and next pc for the current model state
  function automatic ref_out_t model_predict(input logic stall,
                                             input bpu_types_pkg::redirect_t rd);
    ref_out_t                  r;
    bpu_types_pkg::btb_entry_t e;
    logic [31:0]               blk;
    logic [31:0]               seq;
    logic [3:0]                hist;
    logic [1:0]                lphr;
    logic                      hit;
    logic                      cond_tk;
    logic                      ret;
    logic                      jmp;
    logic                      tk;
    e       = m_btb_rd;
    blk     = {m_pc[31:3], 3'b000};
    seq     = blk + 32'd8;
    hit     = e.valid && (e.tag == m_pc[18:9]) && (!m_pc[2] || e.fsc);
    hist    = m_bht[bht_slot(m_pc)];
    lphr    = m_lpht[{m_pc[11:10], hist}];
    cond_tk = hit && e.cond && lphr[1];
    ret     = hit && !e.cond && (e.kind == bpu_cfg_pkg::TGT_RETURN);
    jmp     = hit && !e.cond &&
              (e.kind == bpu_cfg_pkg::TGT_CALL || e.kind == bpu_cfg_pkg::TGT_IMM);
    tk      = cond_tk || ret || jmp;
    if (rd.valid) begin
      r.npc = rd.target;
    end else if (cond_tk || jmp) begin
      r.npc = {e.target_pc, 2'b00};
    end else if (ret) begin
      r.npc = m_ras[m_ptr - 3'd1];
    end else begin
      r.npc = seq;
    end
    r.fetch.pc0   = blk;
    r.fetch.pc1   = blk | 32'd4;
    if (stall) begin
      r.fetch.valid = 2'b00;
    end else if (tk && !e.fsc) begin
      r.fetch.valid = 2'b01;
    end else begin
      r.fetch.valid = m_pc[2] ? 2'b10 : 2'b11;
    end
    r.pred.taken   = tk;
    r.pred.kind    = hit ? e.kind : bpu_cfg_pkg::TGT_NPC;
    r.pred.lphr    = lphr;
    r.pred.history = hist;
    r.pred.ras_ptr = m_ptr;
    r.push         = !stall && jmp && (e.kind == bpu_cfg_pkg::TGT_CALL);
    r.pop          = !stall && ret;
    r.push_addr    = e.fsc ? seq : blk + 32'd4;
    return r;
  endfunction

  // model advances on the same edges as the DUT
  always @(posedge clk) begin
    ref_out_t                  r;
    bpu_types_pkg::btb_entry_t e;
    if (!rst_n) begin
      m_pc     = bpu_cfg_pkg::RESET_PC;
      m_btb_rd = '0;
      m_ptr    = '0;
      for (int i = 0; i < 64; i++) begin
        m_btb[i]  = '0;
        m_bht[i]  = '0;
        m_lpht[i] = '0;
      end
      for (int i = 0; i < 8; i++) begin
        m_ras[i] = '0;
      end
    end else begin
      r = model_predict(stall_i, redirect_i);
      if (!stall_i) begin
        // btb read sees the table before this edge's write
        m_btb_rd = m_btb[r.npc[8:3]];
        m_pc     = r.npc;
      end
      if (correct_i.miss) begin
        if (correct_i.true_kind == bpu_cfg_pkg::TGT_CALL) begin
          m_ras[correct_i.ras_ptr] = correct_i.pc + 32'd4;
          m_ptr                    = correct_i.ras_ptr + 3'd1;
        end else begin
          m_ptr = correct_i.ras_ptr;
        end
      end else if (r.push) begin
        m_ras[m_ptr] = r.push_addr;
        m_ptr        = m_ptr + 3'd1;
      end else if (r.pop) begin
        m_ptr = m_ptr - 3'd1;
      end
      if (correct_i.miss) begin
        e.valid     = 1'b1;
        e.fsc       = correct_i.pc[2];
        e.tag       = correct_i.pc[18:9];
        e.target_pc = correct_i.true_target[31:2];
        e.cond      = correct_i.true_cond;
        e.kind      = correct_i.true_kind;
        m_btb[correct_i.pc[8:3]] = e;
        if (correct_i.true_cond) begin
          m_bht[bht_slot(correct_i.pc)] = {correct_i.history[2:0], correct_i.true_taken};
          m_lpht[{correct_i.pc[11:10], correct_i.history}] =
            lphr_after(correct_i.lphr, correct_i.true_taken);
        end
      end
    end
    r        = model_predict(1'b0, '0);
    exp_pred = r.pred;
  end

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    ref_out_t r;
    if (rst_n) begin
      r      = model_predict(stall_i, redirect_i);
      checks = checks + 1;
      if (fetch_i !== r.fetch) begin
        errs = errs + 1;
        $display("ERR fetch_o exp=%h got=%h at %0t", r.fetch, fetch_i, $time);
      end
      if (predict_i !== r.pred) begin
        errs = errs + 1;
        $display("ERR predict_o exp=%h got=%h at %0t", r.pred, predict_i, $time);
      end
    end
  end

endmodule

// File: dv/bpu_tb.sv
`timescale 1ns/100ps

module bpu_tb;

  localparam logic [31:0] LFSR_SEED  = 32'hddd9_544d;
  localparam logic [31:0] LFSR_POLY  = 32'h8020_0003;
  localparam int          WAIT_LIMIT = 20;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        stall;
  bpu_types_pkg::redirect_t    redirect;
  bpu_types_pkg::bpu_correct_t correct;
  bpu_types_pkg::fetch_t       fetch;
  bpu_types_pkg::bpu_predict_t predict;
  bpu_types_pkg::bpu_predict_t exp_pred;
  int                          err_cnt;
  int                          chk_cnt;
  int                          timeouts = 0;
  logic [31:0]                 lfsr = LFSR_SEED;

  always #20 clk = ~clk;

  bpu_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall_i   (stall),
    .redirect_i(redirect),
    .correct_i (correct),
    .fetch_o   (fetch),
    .predict_o (predict)
  );

  bpu_checker u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall_i   (stall),
    .redirect_i(redirect),
    .correct_i (correct),
    .fetch_i   (fetch),
    .predict_i (predict),
    .exp_pred_o(exp_pred),
    .err_cnt_o (err_cnt),
    .chk_cnt_o (chk_cnt)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic jump_to(input logic [31:0] target);
    redirect.valid  = 1'b1;
    redirect.target = target;
    next_cycle();
    redirect = '0;
  endtask

  function automatic logic at_block(input logic [31:0] addr);
    return (fetch.pc0 === {addr[31:3], 3'b000}) && (fetch.valid !== 2'b00);
  endfunction

  task automatic wait_block(input logic [31:0] addr);
    int n;
    n = 0;
    while (!at_block(addr) && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (!at_block(addr)) begin
      timeouts++;
      $display("timeout while waiting for fetch block %h", addr);
    end
  endtask

  // execute stand-in that takes its metadata from the model's current block
  task automatic send_correct(input logic [31:0] pc, input logic [31:0] target,
                              input logic [1:0] kind, input logic cond,
                              input logic taken);
    correct.miss        = 1'b1;
    correct.pc          = pc;
    correct.true_target = target;
    correct.true_kind   = kind;
    correct.true_cond   = cond;
    correct.true_taken  = taken;
    correct.history     = exp_pred.history;
    correct.lphr        = exp_pred.lphr;
    correct.ras_ptr     = exp_pred.ras_ptr;
    next_cycle();
    correct = '0;
  endtask

  initial begin
    logic [31:0] v;
    logic [3:0]  pattern;
    rst_n    = 1'b0;
    stall    = 1'b0;
    redirect = '0;
    correct  = '0;
    repeat (3) next_cycle();
    rst_n = 1'b1;

    // untrained sequential fetch and then a slot 1 entry point
    repeat (12) next_cycle();
    jump_to(32'h1c00_0104);
    repeat (6) next_cycle();

    // random stalls and redirects with one correction under stall
    for (int i = 0; i < 48; i++) begin
      take_bits(1, v);
      stall = v[0];
      if (i % 12 == 5) begin
        take_bits(10, v);
        redirect.valid  = 1'b1;
        redirect.target = 32'h1c00_0000 + {20'd0, v[9:0], 2'b00};
      end else begin
        redirect = '0;
      end
      if (i == 30) begin
        stall = 1'b1;
        send_correct(32'h1c00_1800, 32'h1c00_1c00, bpu_cfg_pkg::TGT_IMM, 1'b0, 1'b1);
      end else begin
        next_cycle();
      end
    end
    stall    = 1'b0;
    redirect = '0;
    repeat (3) next_cycle();

    // unconditional jumps from slot 0 and from slot 1
    send_correct(32'h1c00_0200, 32'h1c00_0400, bpu_cfg_pkg::TGT_IMM, 1'b0, 1'b1);
    repeat (2) next_cycle();
    jump_to(32'h1c00_0200);
    wait_block(32'h1c00_0200);
    repeat (3) next_cycle();
    send_correct(32'h1c00_0604, 32'h1c00_0800, bpu_cfg_pkg::TGT_IMM, 1'b0, 1'b1);
    repeat (2) next_cycle();
    jump_to(32'h1c00_0600);
    wait_block(32'h1c00_0600);
    repeat (3) next_cycle();
    jump_to(32'h1c00_0604);
    wait_block(32'h1c00_0604);
    repeat (3) next_cycle();

    // call in slot 1 whose target block is a return
    send_correct(32'h1c00_0a04, 32'h1c00_0c10, bpu_cfg_pkg::TGT_CALL, 1'b0, 1'b1);
    send_correct(32'h1c00_0c10, 32'h1c00_0e00, bpu_cfg_pkg::TGT_RETURN, 1'b0, 1'b1);
    repeat (2) next_cycle();
    jump_to(32'h1c00_0a00);
    wait_block(32'h1c00_0a00);
    wait_block(32'h1c00_0c10);
    // correction on the pop edge puts back the pointer from before the pop
    send_correct(32'h1c00_0c10, 32'h1c00_0a08, bpu_cfg_pkg::TGT_RETURN, 1'b0, 1'b1);
    repeat (3) next_cycle();

    // conditional branch with a repeating taken pattern
    take_bits(4, v);
    pattern = v[3:0];
    for (int k = 0; k < 24; k++) begin
      jump_to(32'h1c00_0e00);
      wait_block(32'h1c00_0e00);
      send_correct(32'h1c00_0e00, 32'h1c00_1000, bpu_cfg_pkg::TGT_IMM, 1'b1,
                   pattern[2'(k % 4)]);
      repeat (2) next_cycle();
    end
    repeat (4) next_cycle();

    $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0 && chk_cnt > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: all.f
common/bpu_cfg_pkg.sv
common/bpu_types_pkg.sv
hdl/dp_table.sv
btb/btb_lookup.sv
dir/local_dir_pred.sv
hdl/npc_select.sv
hdl/bpu_top.sv
dv/bpu_checker.sv
dv/bpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bpu_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q -F '*** PASSED ***' $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
